// ==== source/lsq_pkg.sv ====
`default_nettype none

package lsq_pkg;

    // data and address width
    localparam int xlen = 32;

    // reorder buffer tag and physical destination register
    typedef logic [4:0] rob_tag_t;
    typedef logic [6:0] preg_t;

    // access width, stores use word/half, loads use word/byte-unsigned
    typedef enum logic [1:0] {
        mem_word   = 2'd0,
        mem_half   = 2'd1,
        mem_byte_u = 2'd2
    } mem_width_e;

    // major opcodes of the memory instructions
    localparam logic [6:0] opcode_load  = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;

    // func3 values that the queue supports
    localparam logic [2:0] funct3_lw  = 3'b010;
    localparam logic [2:0] funct3_lbu = 3'b100;
    localparam logic [2:0] funct3_sw  = 3'b010;
    localparam logic [2:0] funct3_sh  = 3'b001;

    // one decoded memory operation, address already generated
    typedef struct packed {
        rob_tag_t         rob_tag;
        logic             is_store;
        mem_width_e       width;
        logic [xlen-1:0]  addr;
        logic [xlen-1:0]  store_data;
        preg_t            pd;
    } issue_t;

    // one queue slot
    typedef struct packed {
        logic   valid;
        logic   issued;
        logic   done;
        issue_t op;
    } lsq_entry_t;

    // memory write request, sent at store commit
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
        mem_width_e      width;
    } store_req_t;

    // resolved load, data is zero when forwarded is clear (memory read)
    typedef struct packed {
        rob_tag_t        rob_tag;
        preg_t           pd;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
        logic            forwarded;
    } load_result_t;

    // raw issue bundle, before address generation
    typedef struct packed {
        rob_tag_t        rob_tag;
        logic [6:0]      opcode;
        logic [2:0]      funct3;
        logic [xlen-1:0] base;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] store_data;
        preg_t           pd;
    } raw_issue_t;

endpackage

`default_nettype wire

// ==== source/lsq_issue_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_issue_decode import lsq_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       issue_valid,
    input  wire raw_issue_t issue_in,
    output logic            dec_valid,
    output issue_t          dec
);

    // decoded view of the incoming operation
    issue_t dec_next;
    logic   supported;

    always_comb begin
        dec_next.rob_tag    = issue_in.rob_tag;
        dec_next.pd         = issue_in.pd;
        dec_next.store_data = issue_in.store_data;
        // address generation, base plus immediate
        dec_next.addr       = issue_in.base + issue_in.imm;
        dec_next.is_store   = 1'b0;
        dec_next.width      = mem_word;
        supported           = 1'b0;

        if (issue_in.opcode == opcode_load) begin
            // only lw and lbu are handled
            if (issue_in.funct3 == funct3_lw) begin
                supported = 1'b1;
            end else if (issue_in.funct3 == funct3_lbu) begin
                dec_next.width = mem_byte_u;
                supported      = 1'b1;
            end
        end else if (issue_in.opcode == opcode_store) begin
            dec_next.is_store = 1'b1;
            // only sw and sh are handled
            if (issue_in.funct3 == funct3_sw) begin
                supported = 1'b1;
            end else if (issue_in.funct3 == funct3_sh) begin
                dec_next.width = mem_half;
                supported      = 1'b1;
            end
        end
    end

    // one cycle of decode latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= issue_valid && supported;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && supported) begin
            dec <= dec_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/lsq_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_queue import lsq_pkg::*; #(
    parameter int depth = 8
) (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        dispatch_valid,
    input  wire rob_tag_t                    dispatch_rob_tag,
    output logic                             dispatch_ready,
    input  wire logic                        dec_valid,
    input  wire issue_t                      dec,
    input  wire logic                        mark_done,
    input  wire logic [$clog2(depth)-1:0]    mark_index,
    input  wire logic                        commit_valid,
    input  wire rob_tag_t                    commit_rob_tag,
    output logic                             commit_ready,
    output logic                             store_valid,
    output store_req_t                       store_req,
    input  wire logic                        store_ready,
    output lsq_entry_t [depth-1:0]           entries,
    output logic [$clog2(depth)-1:0]         head
);

    localparam int iw = $clog2(depth);

    // per-entry flags, these carry the reset
    logic [depth-1:0] valid_q;
    logic [depth-1:0] issued_q;
    logic [depth-1:0] done_q;
    // per-entry payload
    issue_t           payload_q [depth];

    logic [iw-1:0]    tail;
    logic [iw:0]      count;

    logic             alloc;
    logic             commit_fire;
    logic             head_match;
    issue_t           head_op;

    // pack flags and payload into the entry view for the resolver
    always_comb begin
        for (int i = 0; i < depth; i++) begin
            entries[i].valid  = valid_q[i];
            entries[i].issued = issued_q[i];
            entries[i].done   = done_q[i];
            entries[i].op     = payload_q[i];
        end
    end

    assign dispatch_ready = (count != (iw+1)'(depth));
    assign alloc          = dispatch_valid && dispatch_ready;

    // head entry, issued and owned by the committing rob tag
    assign head_op    = payload_q[head];
    assign head_match = valid_q[head] && issued_q[head] &&
                        (head_op.rob_tag == commit_rob_tag);

    // store goes out on the write port only when committed at the head
    assign store_valid  = commit_valid && head_match && head_op.is_store;
    assign commit_ready = head_match &&
                          (head_op.is_store ? store_ready : done_q[head]);
    assign commit_fire  = commit_valid && commit_ready;

    assign store_req = '{addr: head_op.addr, data: head_op.store_data, width: head_op.width};

    // flags, pointers and occupancy
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q  <= '0;
            issued_q <= '0;
            done_q   <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
        end else begin
            // tag match fill, dropped when no unissued entry owns the tag
            if (dec_valid) begin
                for (int i = 0; i < depth; i++) begin
                    if (valid_q[i] && !issued_q[i] && payload_q[i].rob_tag == dec.rob_tag) begin
                        issued_q[i] <= 1'b1;
                    end
                end
            end
            // resolver captured this load
            if (mark_done) begin
                done_q[mark_index] <= 1'b1;
            end
            // free head in order
            if (commit_fire) begin
                valid_q[head] <= 1'b0;
                head          <= head + 1'b1;
            end
            // reserve next tail slot in program order
            if (alloc) begin
                valid_q[tail]  <= 1'b1;
                issued_q[tail] <= 1'b0;
                done_q[tail]   <= 1'b0;
                tail           <= tail + 1'b1;
            end
            case ({alloc, commit_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            for (int i = 0; i < depth; i++) begin
                if (valid_q[i] && !issued_q[i] && payload_q[i].rob_tag == dec.rob_tag) begin
                    payload_q[i] <= dec;
                end
            end
        end
        // only the tag is known at dispatch
        if (alloc) begin
            payload_q[tail].rob_tag <= dispatch_rob_tag;
        end
    end

endmodule

`default_nettype wire

// ==== source/lsq_load_resolver.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_load_resolver import lsq_pkg::*; #(
    parameter int depth = 8
) (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire lsq_entry_t [depth-1:0]      entries,
    input  wire logic [$clog2(depth)-1:0]    head,
    output logic                             mark_done,
    output logic [$clog2(depth)-1:0]         mark_index,
    output logic                             load_valid,
    output load_result_t                     load_result,
    input  wire logic                        load_ready
);

    localparam int iw = $clog2(depth);

    // byte count of an access width
    function automatic logic [2:0] width_bytes(input mem_width_e w);
        case (w)
            mem_word: return 3'd4;
            mem_half: return 3'd2;
            default:  return 3'd1;
        endcase
    endfunction

    // byte ranges intersect, one extra bit so the top of memory does not wrap
    function automatic logic overlaps(input issue_t s, input issue_t l);
        logic [xlen:0] s_lo;
        logic [xlen:0] l_lo;
        s_lo = {1'b0, s.addr};
        l_lo = {1'b0, l.addr};
        return (l_lo < s_lo + width_bytes(s.width)) && (s_lo < l_lo + width_bytes(l.width));
    endfunction

    logic          found_load;
    int            load_age;
    logic [iw-1:0] load_idx;
    issue_t        ld;
    logic          stall;
    logic          hit;
    issue_t        st;
    logic [1:0]    byte_off;
    logic          fwd_ok;
    logic          resolvable;
    logic          capture;
    load_result_t  res_next;

    always_comb begin
        logic [iw-1:0] pos;
        // oldest issued load that has no result yet
        found_load = 1'b0;
        load_age   = 0;
        load_idx   = head;
        for (int k = 0; k < depth; k++) begin
            pos = head + iw'(k);
            if (!found_load && entries[pos].valid && entries[pos].issued) begin
                if (!entries[pos].op.is_store && !entries[pos].done) begin
                    found_load = 1'b1;
                    load_age   = k;
                    load_idx   = pos;
                end
            end
        end
        ld = entries[load_idx].op;

        // walk the older entries, later matches are younger and win
        stall = 1'b0;
        hit   = 1'b0;
        st    = '0;
        for (int k = 0; k < depth; k++) begin
            pos = head + iw'(k);
            if (k < load_age && entries[pos].valid) begin
                if (!entries[pos].issued) begin
                    stall = 1'b1;
                end else if (entries[pos].op.is_store && overlaps(entries[pos].op, ld)) begin
                    hit = 1'b1;
                    st  = entries[pos].op;
                end
            end
        end
    end

    // forward decision against the youngest overlapping store
    always_comb begin
        byte_off = ld.addr[1:0] - st.addr[1:0];
        res_next.rob_tag   = ld.rob_tag;
        res_next.pd        = ld.pd;
        res_next.addr      = ld.addr;
        res_next.forwarded = hit;
        res_next.data      = '0;
        fwd_ok             = 1'b0;
        if (st.width == mem_word && ld.width == mem_word && st.addr == ld.addr) begin
            // word to word, same address
            fwd_ok        = 1'b1;
            res_next.data = st.store_data;
        end else if (ld.width == mem_byte_u) begin
            // lbu inside the store, zero extended
            fwd_ok        = 1'b1;
            res_next.data = {24'b0, st.store_data[{byte_off, 3'b000} +: 8]};
        end
    end

    // partial overlap blocks until the store leaves the queue
    assign resolvable = found_load && !stall && (!hit || fwd_ok);
    assign capture    = resolvable && (!load_valid || load_ready);
    assign mark_done  = capture;
    assign mark_index = load_idx;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_valid <= 1'b0;
        end else if (capture) begin
            load_valid <= 1'b1;
        end else if (load_ready) begin
            load_valid <= 1'b0;
        end
    end

    // held until the consumer takes it
    always_ff @(posedge clk) begin
        if (capture) begin
            load_result <= res_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/lsq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_top import lsq_pkg::*; #(
    parameter int depth = 8
) (
    input  wire logic         clk,
    input  wire logic         reset,
    // dispatch, program order reservation
    input  wire logic         dispatch_valid,
    input  wire rob_tag_t     dispatch_rob_tag,
    output logic              dispatch_ready,
    // issue, always accepted
    input  wire logic         issue_valid,
    input  wire raw_issue_t   issue_in,
    // commit from the reorder buffer
    input  wire logic         commit_valid,
    input  wire rob_tag_t     commit_rob_tag,
    output logic              commit_ready,
    // memory write port
    output logic              store_valid,
    output store_req_t        store_req,
    input  wire logic         store_ready,
    // resolved loads
    output logic              load_valid,
    output load_result_t      load_result,
    input  wire logic         load_ready
);

    logic                     dec_valid;
    issue_t                   dec;
    logic                     mark_done;
    logic [$clog2(depth)-1:0] mark_index;
    lsq_entry_t [depth-1:0]   entries;
    logic [$clog2(depth)-1:0] head;

    lsq_issue_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_in    (issue_in),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

    lsq_queue #(.depth(depth)) u_queue (
        .clk              (clk),
        .reset            (reset),
        .dispatch_valid   (dispatch_valid),
        .dispatch_rob_tag (dispatch_rob_tag),
        .dispatch_ready   (dispatch_ready),
        .dec_valid        (dec_valid),
        .dec              (dec),
        .mark_done        (mark_done),
        .mark_index       (mark_index),
        .commit_valid     (commit_valid),
        .commit_rob_tag   (commit_rob_tag),
        .commit_ready     (commit_ready),
        .store_valid      (store_valid),
        .store_req        (store_req),
        .store_ready      (store_ready),
        .entries          (entries),
        .head             (head)
    );

    lsq_load_resolver #(.depth(depth)) u_resolver (
        .clk         (clk),
        .reset       (reset),
        .entries     (entries),
        .head        (head),
        .mark_done   (mark_done),
        .mark_index  (mark_index),
        .load_valid  (load_valid),
        .load_result (load_result),
        .load_ready  (load_ready)
    );

endmodule

`default_nettype wire

// ==== tb/lsq_tb_tasks.svh ====
// typed compares, one per kind of result
task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        fail_stop($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
    end
endtask

task automatic check_load(input string name, input load_result_t exp, input load_result_t act);
    if (act !== exp) begin
        fail_stop($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic check_store(input string name, input store_req_t exp, input store_req_t act);
    if (act !== exp) begin
        fail_stop($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
    end
endtask

// stimulus and expected value builders
function automatic raw_issue_t load_op(input rob_tag_t tag, input logic [2:0] f3,
        input logic [31:0] base, input logic [31:0] imm, input preg_t pd);
    return '{rob_tag: tag, opcode: opcode_load, funct3: f3, base: base, imm: imm,
             store_data: 32'h0, pd: pd};
endfunction

function automatic raw_issue_t store_op(input rob_tag_t tag, input logic [2:0] f3,
        input logic [31:0] base, input logic [31:0] imm, input logic [31:0] data);
    return '{rob_tag: tag, opcode: opcode_store, funct3: f3, base: base, imm: imm,
             store_data: data, pd: '0};
endfunction

function automatic load_result_t load_exp(input rob_tag_t tag, input preg_t pd,
        input logic [31:0] addr, input logic [31:0] data, input logic fwd);
    return '{rob_tag: tag, pd: pd, addr: addr, data: data, forwarded: fwd};
endfunction

function automatic store_req_t store_exp(input logic [31:0] addr, input logic [31:0] data,
        input mem_width_e width);
    return '{addr: addr, data: data, width: width};
endfunction

// byte k of a store word, zero extended
function automatic logic [31:0] byte_of(input logic [31:0] data, input int k);
    return {24'b0, data[8*k +: 8]};
endfunction

// reserve the next tag in program order
task automatic dispatch_next(output rob_tag_t tag);
    tag      = next_tag;
    next_tag = next_tag + 5'd1;
    @(posedge clk);
    dispatch_valid   <= 1'b1;
    dispatch_rob_tag <= tag;
    @(negedge clk);
    while (!dispatch_ready) @(negedge clk);
    @(posedge clk);
    dispatch_valid <= 1'b0;
endtask

task automatic issue_op(input raw_issue_t op);
    @(posedge clk);
    issue_valid <= 1'b1;
    issue_in    <= op;
    @(posedge clk);
    issue_valid <= 1'b0;
    // entry is filled on the following edge
    @(posedge clk);
endtask

task automatic commit_load(input string name, input rob_tag_t tag);
    @(posedge clk);
    commit_valid   <= 1'b1;
    commit_rob_tag <= tag;
    @(negedge clk);
    while (!commit_ready) @(negedge clk);
    check_flag({name, " store_valid"}, 1'b0, store_valid);
    @(posedge clk);
    commit_valid <= 1'b0;
endtask

// hold > 0 keeps store_ready low for that many cycles first
task automatic commit_store(input string name, input rob_tag_t tag, input store_req_t exp,
        input int hold);
    @(posedge clk);
    commit_valid   <= 1'b1;
    commit_rob_tag <= tag;
    store_ready    <= (hold == 0);
    if (hold > 0) begin
        repeat (hold) begin
            @(negedge clk);
            check_flag({name, " commit_ready held"}, 1'b0, commit_ready);
            check_flag({name, " store_valid held"}, 1'b1, store_valid);
            check_store(name, exp, store_req);
        end
        @(posedge clk);
        store_ready <= 1'b1;
    end
    @(negedge clk);
    while (!commit_ready) @(negedge clk);
    check_flag({name, " store_valid"}, 1'b1, store_valid);
    check_store(name, exp, store_req);
    @(posedge clk);
    commit_valid <= 1'b0;
endtask

// wait for a result, optionally hold it, then take it with one ready edge
task automatic take_load(input string name, input load_result_t exp, input int hold);
    @(negedge clk);
    while (!load_valid) @(negedge clk);
    check_load(name, exp, load_result);
    repeat (hold) begin
        @(negedge clk);
        check_flag({name, " load_valid held"}, 1'b1, load_valid);
        check_load({name, " held"}, exp, load_result);
    end
    @(posedge clk);
    load_ready <= 1'b1;
    @(posedge clk);
    load_ready <= 1'b0;
endtask

task automatic expect_no_load(input string name, input int cycles);
    repeat (cycles) begin
        @(negedge clk);
        check_flag(name, 1'b0, load_valid);
    end
endtask

// full queue of loads, each a memory read, freed in order
task automatic test_fill_and_free();
    rob_tag_t    tags  [depth];
    preg_t       pds   [depth];
    logic [31:0] addrs [depth];
    logic [31:0] base;
    logic [31:0] imm;
    for (int i = 0; i < depth; i++) dispatch_next(tags[i]);
    @(negedge clk);
    check_flag("fill dispatch_ready when full", 1'b0, dispatch_ready);
    for (int i = 0; i < depth; i++) begin
        base     = rand_addr();
        imm      = rand_bits(8);
        pds[i]   = preg_t'(rand_bits(7));
        addrs[i] = base + imm;
        issue_op(load_op(tags[i], funct3_lw, base, imm, pds[i]));
    end
    for (int i = 0; i < depth; i++) begin
        take_load("fill read", load_exp(tags[i], pds[i], addrs[i], 32'h0, 1'b0), 0);
    end
    commit_load("fill commit", tags[0]);
    @(negedge clk);
    check_flag("fill dispatch_ready after commit", 1'b1, dispatch_ready);
    for (int i = 1; i < depth; i++) commit_load("fill commit", tags[i]);
endtask

// word store under write back-pressure, then a half store
task automatic test_store_commit();
    rob_tag_t    tag;
    logic [31:0] base;
    logic [31:0] imm;
    logic [31:0] data;
    dispatch_next(tag);
    base = rand_addr();
    imm  = rand_bits(8);
    data = rand_bits(32);
    issue_op(store_op(tag, funct3_sw, base, imm, data));
    commit_store("store word", tag, store_exp(base + imm, data, mem_word), 4);
    dispatch_next(tag);
    base = rand_addr();
    imm  = 32'd6;
    data = rand_bits(32);
    issue_op(store_op(tag, funct3_sh, base, imm, data));
    commit_store("store half", tag, store_exp(base + imm, data, mem_half), 0);
endtask

task automatic test_forwarding();
    rob_tag_t    t  [5];
    preg_t       pd [3];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d0;
    logic [31:0] d1;
    int          k0;
    int          k1;
    // sw, lw, lbu, sh, lbu in program order
    for (int i = 0; i < 5; i++) dispatch_next(t[i]);
    for (int i = 0; i < 3; i++) pd[i] = preg_t'(rand_bits(7));
    a  = rand_addr();
    b  = a + 32'd18;
    d0 = rand_bits(32);
    d1 = rand_bits(32);
    k0 = int'(rand_bits(2));
    k1 = int'(rand_bits(1));
    issue_op(store_op(t[0], funct3_sw, a, 32'd0, d0));
    issue_op(load_op(t[1], funct3_lw, a - 32'd4, 32'd4, pd[0]));
    issue_op(load_op(t[2], funct3_lbu, a, 32'(k0), pd[1]));
    issue_op(store_op(t[3], funct3_sh, b, 32'd0, d1));
    issue_op(load_op(t[4], funct3_lbu, b, 32'(k1), pd[2]));
    take_load("fwd word", load_exp(t[1], pd[0], a, d0, 1'b1), 0);
    take_load("fwd byte of word", load_exp(t[2], pd[1], a + 32'(k0), byte_of(d0, k0), 1'b1), 0);
    take_load("fwd byte of half", load_exp(t[4], pd[2], b + 32'(k1), byte_of(d1, k1), 1'b1), 0);
    commit_store("fwd store word", t[0], store_exp(a, d0, mem_word), 0);
    commit_load("fwd commit", t[1]);
    commit_load("fwd commit", t[2]);
    commit_store("fwd store half", t[3], store_exp(b, d1, mem_half), 0);
    commit_load("fwd commit", t[4]);
    // two older stores to one word
    for (int i = 0; i < 3; i++) dispatch_next(t[i]);
    d0 = rand_bits(32);
    d1 = rand_bits(32);
    issue_op(store_op(t[0], funct3_sw, a, 32'd0, d0));
    issue_op(store_op(t[1], funct3_sw, a, 32'd0, d1));
    issue_op(load_op(t[2], funct3_lw, a, 32'd0, pd[0]));
    take_load("fwd younger store", load_exp(t[2], pd[0], a, d1, 1'b1), 0);
    commit_store("fwd older store", t[0], store_exp(a, d0, mem_word), 0);
    commit_store("fwd younger store", t[1], store_exp(a, d1, mem_word), 0);
    commit_load("fwd commit", t[2]);
endtask

// load waits behind an unissued store, then reads memory
task automatic test_stall_then_read();
    rob_tag_t    ts;
    rob_tag_t    tl;
    preg_t       pd;
    logic [31:0] a;
    logic [31:0] d;
    dispatch_next(ts);
    dispatch_next(tl);
    a  = rand_addr();
    d  = rand_bits(32);
    pd = preg_t'(rand_bits(7));
    issue_op(load_op(tl, funct3_lw, a, 32'd0, pd));
    expect_no_load("stall on unissued store", 8);
    issue_op(store_op(ts, funct3_sw, a + 32'd64, 32'd0, d));
    take_load("read after stall", load_exp(tl, pd, a, 32'h0, 1'b0), 0);
    commit_store("stall store", ts, store_exp(a + 32'd64, d, mem_word), 0);
    commit_load("stall commit", tl);
endtask

// word load over an older half store waits for its commit
task automatic test_blocking();
    rob_tag_t    ts;
    rob_tag_t    tl;
    preg_t       pd;
    logic [31:0] a;
    logic [31:0] d;
    dispatch_next(ts);
    dispatch_next(tl);
    a  = rand_addr();
    d  = rand_bits(32);
    pd = preg_t'(rand_bits(7));
    issue_op(store_op(ts, funct3_sh, a, 32'd2, d));
    issue_op(load_op(tl, funct3_lw, a, 32'd0, pd));
    expect_no_load("block on half store", 8);
    commit_store("block store", ts, store_exp(a + 32'd2, d, mem_half), 0);
    take_load("read after block", load_exp(tl, pd, a, 32'h0, 1'b0), 0);
    commit_load("block commit", tl);
endtask

// held result stays put, each load comes out once
task automatic test_result_backpressure();
    rob_tag_t    t  [2];
    preg_t       pd [2];
    logic [31:0] a  [2];
    for (int i = 0; i < 2; i++) begin
        dispatch_next(t[i]);
        pd[i] = preg_t'(rand_bits(7));
        a[i]  = rand_addr();
    end
    for (int i = 0; i < 2; i++) issue_op(load_op(t[i], funct3_lw, a[i], 32'd0, pd[i]));
    take_load("held first result", load_exp(t[0], pd[0], a[0], 32'h0, 1'b0), 6);
    take_load("second result", load_exp(t[1], pd[1], a[1], 32'h0, 1'b0), 0);
    expect_no_load("no repeated result", 6);
    commit_load("backpressure commit", t[0]);
    commit_load("backpressure commit", t[1]);
endtask

// ==== tb/lsq_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_tb import lsq_pkg::*; ();

    localparam int depth      = 8;
    localparam int clk_period = 40;

    // cycle budget per directed test, summed for the watchdog
    localparam int reset_cycles  = 8;
    localparam int fill_cycles   = 160;
    localparam int store_cycles  = 60;
    localparam int fwd_cycles    = 140;
    localparam int stall_cycles  = 60;
    localparam int block_cycles  = 60;
    localparam int bp_cycles     = 80;
    localparam int watchdog_cycles = reset_cycles + fill_cycles + store_cycles +
                                     fwd_cycles + stall_cycles + block_cycles + bp_cycles;

    // word aligned, far from the top of memory
    localparam logic [31:0] addr_mask = 32'h0fff_ff00;

    logic         clk;
    logic         reset;
    logic         dispatch_valid;
    rob_tag_t     dispatch_rob_tag;
    logic         dispatch_ready;
    logic         issue_valid;
    raw_issue_t   issue_in;
    logic         commit_valid;
    rob_tag_t     commit_rob_tag;
    logic         commit_ready;
    logic         store_valid;
    store_req_t   store_req;
    logic         store_ready;
    logic         load_valid;
    load_result_t load_result;
    logic         load_ready;

    // lfsr state and next rob tag to hand out
    logic [31:0]  lfsr_state;
    rob_tag_t     next_tag;

    lsq_top #(.depth(depth)) dut0 (
        .clk              (clk),
        .reset            (reset),
        .dispatch_valid   (dispatch_valid),
        .dispatch_rob_tag (dispatch_rob_tag),
        .dispatch_ready   (dispatch_ready),
        .issue_valid      (issue_valid),
        .issue_in         (issue_in),
        .commit_valid     (commit_valid),
        .commit_rob_tag   (commit_rob_tag),
        .commit_ready     (commit_ready),
        .store_valid      (store_valid),
        .store_req        (store_req),
        .store_ready      (store_ready),
        .load_valid       (load_valid),
        .load_result      (load_result),
        .load_ready       (load_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [31:0] rand_addr();
        return rand_bits(32) & addr_mask;
    endfunction

    // report and stop at the first failure
    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    `include "lsq_tb_tasks.svh"

    initial begin
        #(watchdog_cycles * clk_period);
        fail_stop("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        reset            = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch_rob_tag = '0;
        issue_valid      = 1'b0;
        issue_in         = '0;
        commit_valid     = 1'b0;
        commit_rob_tag   = '0;
        store_ready      = 1'b1;
        load_ready       = 1'b0;
        lfsr_state       = 32'h8f90_a095;
        next_tag         = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        // idle outputs right after reset
        @(negedge clk);
        check_flag("reset dispatch_ready", 1'b1, dispatch_ready);
        check_flag("reset load_valid", 1'b0, load_valid);
        check_flag("reset store_valid", 1'b0, store_valid);
        check_flag("reset commit_ready", 1'b0, commit_ready);
        test_fill_and_free();
        test_store_commit();
        test_forwarding();
        test_stall_then_read();
        test_blocking();
        test_result_backpressure();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+tb
source/lsq_pkg.sv
source/lsq_issue_decode.sv
source/lsq_queue.sv
source/lsq_load_resolver.sv
source/lsq_top.sv
tb/lsq_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the lsq testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f src.f --top-module lsq_tb -o Vlsq_tb
# a failing run exits nonzero, keep the log for the search below
./obj_dir/Vlsq_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Some tests failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
grep -q "All tests passed" sim.log
echo "simulation passed"
